//--- Makefile
# Verilator build of the DMA control block testbench

VERILATOR ?= verilator
TOP       ?= hyper_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulator is the pass or fail result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

//--- all.f
source/hyper_pkg.sv
source/desc_mem.sv
source/block_mover.sv
source/block_cmd_engine.sv
source/slot_scheduler.sv
source/hyper_top.sv
tb/hyper_tb.sv

//--- source/block_cmd_engine.sv
`timescale 1ns/1ps

module block_cmd_engine (
  input  logic                 CLK,
  input  logic                 RST,
  // command from the scheduler
  input  logic                 go,
  input  hyper_pkg::addr_t     new_addr,
  input  hyper_pkg::blk_len_t  block_len,
  input  hyper_pkg::section_t  new_section,
  input  logic                 new_dir,
  input  logic [1:0]           select_mvblck,
  input  hyper_pkg::desc_idx_t new_idx,
  output logic                 ready,
  output hyper_pkg::addr_t     old_addr,
  output hyper_pkg::blk_len_t  count_sent,
  output logic                 restart,
  output logic                 done_pulse,
  // mcu
  output logic [1:0]           mcu_req,
  input  logic [1:0]           mcu_grant,
  output hyper_pkg::page_t     page_addr,
  // word stream
  output logic                 xfer_valid,
  output hyper_pkg::addr_t     xfer_addr,
  output hyper_pkg::desc_idx_t xfer_idx,
  output logic                 xfer_dir,
  output hyper_pkg::section_t  xfer_section
);
  import hyper_pkg::*;

  eng_state_t           state;
  logic [PAGE_BITS-1:0] offset;
  logic [PAGE_BITS:0]   words_left;
  logic                 crosses, cross_q;
  blk_len_t             count_req, mv_sent;
  logic                 issue, working, working_q, grant_ok, move_end;

  assign ready      = state == ENG_IDLE;
  assign done_pulse = state == ENG_DONE;

  assign words_left = (PAGE_BITS + 1)'(PAGE_WORDS) - {1'b0, offset};
  assign crosses    = (PAGE_BITS + 1)'(block_len) > words_left;

  assign grant_ok = |(mcu_req & mcu_grant);
  assign move_end = (state == ENG_MOVE) && working_q && !working;  // falling edge of working

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      state     <= ENG_IDLE;
      mcu_req   <= '0;
      issue     <= 1'b0;
      working_q <= 1'b0;
      restart   <= 1'b0;
    end
    else
    begin
      working_q <= working;
      issue     <= state == ENG_SIZE;
      case (state)
        ENG_IDLE:
          if (go)
            state <= ENG_LATCH;
        ENG_LATCH:
        begin
          mcu_req <= select_mvblck;
          state   <= ENG_SIZE;
        end
        ENG_SIZE:
          state <= ENG_MOVE;
        ENG_MOVE:
          if (move_end)
          begin
            mcu_req <= '0;
            restart <= cross_q;
            state   <= ENG_DONE;
          end
        default:
          state <= ENG_IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK)
  begin
    if (state == ENG_LATCH)
    begin
      page_addr    <= new_addr[31:PAGE_BITS];
      offset       <= new_addr[PAGE_BITS-1:0];
      xfer_idx     <= new_idx;
      xfer_dir     <= new_dir;
      xfer_section <= new_section;
    end
    if (state == ENG_SIZE)
    begin
      // cut at the page edge, the scheduler reissues the rest
      count_req <= crosses ? blk_len_t'(words_left) : block_len;
      cross_q   <= crosses;
    end
    if (move_end)
    begin
      count_sent <= mv_sent;
      old_addr   <= {page_addr, offset} + addr_t'(mv_sent);
    end
  end

  block_mover mover_i (
    .CLK        (CLK),
    .RST        (RST),
    .issue      (issue),
    .start_addr ({page_addr, offset}),
    .count_req  (count_req),
    .grant_ok   (grant_ok),
    .working    (working),
    .count_sent (mv_sent),
    .xfer_valid (xfer_valid),
    .xfer_addr  (xfer_addr)
  );

  a_req_in_block : assert property (@(posedge CLK) disable iff (!RST)
    (state == ENG_MOVE) |-> (count_req <= block_len));

endmodule

//--- source/block_mover.sv
`timescale 1ns/1ps

module block_mover (
  input  logic                CLK,
  input  logic                RST,
  input  logic                issue,
  input  hyper_pkg::addr_t    start_addr,
  input  hyper_pkg::blk_len_t count_req,
  input  logic                grant_ok,
  output logic                working,
  output hyper_pkg::blk_len_t count_sent,
  output logic                xfer_valid,
  output hyper_pkg::addr_t    xfer_addr
);
  import hyper_pkg::*;

  blk_len_t goal;
  logic     last_beat;

  assign xfer_valid = working && grant_ok;  // hold while not granted
  assign last_beat  = xfer_valid && (blk_len_t'(count_sent + 1'b1) == goal);

  always_ff @(posedge CLK)
  begin
    if (!RST)
      working <= 1'b0;
    else if (issue)
      working <= count_req != '0;
    else if (last_beat)
      working <= 1'b0;
  end

  always_ff @(posedge CLK)
  begin
    if (issue)
    begin
      goal       <= count_req;
      count_sent <= '0;
      xfer_addr  <= start_addr;
    end
    else if (xfer_valid)
    begin
      count_sent <= count_sent + 1'b1;
      xfer_addr  <= xfer_addr + 1'b1;
    end
  end

endmodule

//--- source/desc_mem.sv
`timescale 1ns/1ps

module desc_mem (
  input  logic                 CLK,
  input  logic                 RST,
  // apb
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  logic [4:0]           paddr,
  input  logic [31:0]          pwdata,
  output logic [31:0]          prdata,
  output logic                 pready,
  // scheduler port
  input  logic                 sched_rd,
  input  hyper_pkg::desc_idx_t sched_rd_idx,
  output hyper_pkg::desc_t     sched_rd_data,
  input  logic                 sched_wr,
  input  hyper_pkg::desc_idx_t sched_wr_idx,
  input  hyper_pkg::desc_t     sched_wr_data
);
  import hyper_pkg::*;

  desc_t       mem [8];
  logic [31:0] stage_lo;      // low half waits here for the high half
  desc_idx_t   cpu_idx;
  logic        hi_half;
  logic        mapped;
  logic        cpu_hit;
  logic        tok_ok;

  // entry index is paddr[4:3] with paddr[0] as its lsb
  assign hi_half = paddr[2];
  assign cpu_idx = {paddr[4:3], paddr[0]};
  assign mapped  = !paddr[1];     // bit 1 set is an unmapped hole

  // scheduler read wins the cycle
  assign cpu_hit = psel && penable && !pready && !sched_rd;

  assign tok_ok = mem[sched_wr_idx][TOKEN_BIT] == sched_wr_data[TOKEN_BIT];

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      for (int i = 0; i < 8; i++)
        mem[i] <= '0;
      pready <= 1'b0;
    end
    else
    begin
      pready <= cpu_hit;
      if (sched_wr && tok_ok)
        mem[sched_wr_idx] <= sched_wr_data;
      // cpu write lands last so it beats a same-cycle write-back
      if (cpu_hit && pwrite && mapped && hi_half)
        mem[cpu_idx] <= {pwdata, stage_lo};
    end
  end

  always_ff @(posedge CLK)
  begin
    if (sched_rd)
      sched_rd_data <= mem[sched_rd_idx];
    if (cpu_hit && pwrite && mapped && !hi_half)
      stage_lo <= pwdata;
    if (cpu_hit && !pwrite)
    begin
      if (!mapped)
        prdata <= '0;
      else if (hi_half)
        prdata <= mem[cpu_idx][63:32];
      else
        prdata <= mem[cpu_idx][31:0];
    end
  end

  // the scheduler keeps an entry off its read slot while it writes it back
  a_rd_wr_apart : assert property (@(posedge CLK) disable iff (!RST)
    !(sched_rd && sched_wr && (sched_rd_idx == sched_wr_idx)));

endmodule

//--- source/hyper_pkg.sv
package hyper_pkg;

  // descriptor and field types
  typedef logic [63:0] desc_t;
  typedef logic [23:0] len_t;
  typedef logic [31:0] addr_t;
  typedef logic [5:0]  blk_len_t;
  typedef logic [2:0]  desc_idx_t;
  typedef logic [1:0]  section_t;

  // descriptor bit positions
  localparam int TOKEN_BIT  = 61;
  localparam int ACTIVE_BIT = 60;
  localparam int DMEM_BIT   = 59;
  localparam int DIR_BIT    = 58;  // 1 = read from memory
  localparam int SECT_LSB   = 56;
  localparam int LEN_LSB    = 32;

  localparam int BLK_MAX = 63;

  // dram paging
  localparam int PAGE_BITS  = 12;
  localparam int PAGE_WORDS = 1 << PAGE_BITS;

  typedef logic [31-PAGE_BITS:0] page_t;

  typedef enum logic [2:0] {
    ENG_IDLE,
    ENG_LATCH,
    ENG_SIZE,
    ENG_MOVE,
    ENG_DONE
  } eng_state_t;

endpackage

//--- source/hyper_top.sv
`timescale 1ns/1ps

module hyper_top #(
  parameter int SLOT_PERIOD = 192
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  logic [4:0]           paddr,
  input  logic [31:0]          pwdata,
  output logic [31:0]          prdata,
  output logic                 pready,
  input  logic [7:0]           periph_busy,
  input  logic [1:0]           mcu_grant,
  output logic [1:0]           mcu_req,
  output hyper_pkg::page_t     page_addr,
  output logic                 xfer_valid,
  output hyper_pkg::addr_t     xfer_addr,
  output hyper_pkg::desc_idx_t xfer_idx,
  output logic                 xfer_dir,
  output hyper_pkg::section_t  xfer_section,
  output logic                 irq,
  output hyper_pkg::desc_idx_t irq_idx,
  output logic                 refresh_strobe
);
  import hyper_pkg::*;

  logic       sched_rd, sched_wr;
  desc_idx_t  sched_rd_idx, sched_wr_idx, cmd_idx;
  desc_t      sched_rd_data, sched_wr_data;
  logic       go, new_dir, ready, restart, done_pulse;
  addr_t      new_addr, old_addr;
  blk_len_t   block_len, count_sent;
  section_t   new_section;
  logic [1:0] select_mvblck;

  desc_mem mem_i (
    .CLK(CLK), .RST(RST),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
    .pwdata(pwdata), .prdata(prdata), .pready(pready),
    .sched_rd(sched_rd), .sched_rd_idx(sched_rd_idx), .sched_rd_data(sched_rd_data),
    .sched_wr(sched_wr), .sched_wr_idx(sched_wr_idx), .sched_wr_data(sched_wr_data)
  );

  slot_scheduler #(.SLOT_PERIOD(SLOT_PERIOD)) sched_i (
    .CLK(CLK), .RST(RST), .periph_busy(periph_busy),
    .sched_rd(sched_rd), .sched_rd_idx(sched_rd_idx), .sched_rd_data(sched_rd_data),
    .sched_wr(sched_wr), .sched_wr_idx(sched_wr_idx), .sched_wr_data(sched_wr_data),
    .go(go), .new_addr(new_addr), .block_len(block_len), .new_section(new_section),
    .new_dir(new_dir), .select_mvblck(select_mvblck), .xfer_idx(cmd_idx),
    .ready(ready), .old_addr(old_addr), .count_sent(count_sent),
    .restart(restart), .done_pulse(done_pulse),
    .irq(irq), .irq_idx(irq_idx), .refresh_strobe(refresh_strobe)
  );

  block_cmd_engine engine_i (
    .CLK(CLK), .RST(RST),
    .go(go), .new_addr(new_addr), .block_len(block_len), .new_section(new_section),
    .new_dir(new_dir), .select_mvblck(select_mvblck), .new_idx(cmd_idx),
    .ready(ready), .old_addr(old_addr), .count_sent(count_sent),
    .restart(restart), .done_pulse(done_pulse),
    .mcu_req(mcu_req), .mcu_grant(mcu_grant), .page_addr(page_addr),
    .xfer_valid(xfer_valid), .xfer_addr(xfer_addr), .xfer_idx(xfer_idx),
    .xfer_dir(xfer_dir), .xfer_section(xfer_section)
  );

endmodule

//--- source/slot_scheduler.sv
`timescale 1ns/1ps

module slot_scheduler #(
  parameter int SLOT_PERIOD = 192
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic [7:0]           periph_busy,
  // descriptor memory
  output logic                 sched_rd,
  output hyper_pkg::desc_idx_t sched_rd_idx,
  input  hyper_pkg::desc_t     sched_rd_data,
  output logic                 sched_wr,
  output hyper_pkg::desc_idx_t sched_wr_idx,
  output hyper_pkg::desc_t     sched_wr_data,
  // engine command
  output logic                 go,
  output hyper_pkg::addr_t     new_addr,
  output hyper_pkg::blk_len_t  block_len,
  output hyper_pkg::section_t  new_section,
  output logic                 new_dir,
  output logic [1:0]           select_mvblck,
  output hyper_pkg::desc_idx_t xfer_idx,
  input  logic                 ready,
  input  hyper_pkg::addr_t     old_addr,
  input  hyper_pkg::blk_len_t  count_sent,
  input  logic                 restart,
  input  logic                 done_pulse,
  // status
  output logic                 irq,
  output hyper_pkg::desc_idx_t irq_idx,
  output logic                 refresh_strobe
);
  import hyper_pkg::*;

  localparam int SMALL_W = $clog2(SLOT_PERIOD);

  logic [SMALL_W-1:0] small_car;
  logic [3:0]         big_car;
  logic               slot_fast0, slot_fast1, slot_slow;
  desc_idx_t          slot_idx;
  logic [7:0]         inflight;     // pending or moving, kept off the read slots

  logic               rd_q, fq_v, pend_v;
  desc_idx_t          rd_idx_q, fq_idx, pend_idx, cand_idx;
  desc_t              fq_data, pend_data, cand_data;
  logic               accept, keep, pend_load, cand_v, disp;
  len_t               cand_len, cur_len, new_len;
  logic [7:0]         cur_hi;
  blk_len_t           sent_acc, sent_total;
  logic [1:0]         ref_req, ref_ack;
  logic               ref_due, ref_serve;

  // ----------------------------------------
  // slot map
  assign slot_fast0 = small_car == '0;
  assign slot_fast1 = small_car == SMALL_W'(SLOT_PERIOD / 2);
  assign slot_slow  = (small_car == SMALL_W'(2)) && !big_car[0] && (big_car >= 4'd4);
  assign slot_idx   = slot_fast0 ? 3'd0 : (slot_fast1 ? 3'd1 : big_car[3:1]);

  assign sched_rd     = (slot_fast0 || slot_fast1 || slot_slow) && !inflight[slot_idx];
  assign sched_rd_idx = slot_idx;

  // ----------------------------------------
  // fetch evaluation and dispatch
  assign accept = fq_v && fq_data[ACTIVE_BIT] && (fq_data[LEN_LSB +: $bits(len_t)] != '0) &&
                  !periph_busy[fq_data[DIR_BIT:SECT_LSB]];

  assign cand_v    = pend_v || accept;
  assign cand_data = pend_v ? pend_data : fq_data;
  assign cand_idx  = pend_v ? pend_idx : fq_idx;
  assign cand_len  = cand_data[LEN_LSB +: $bits(len_t)];

  assign ref_due   = ref_req != ref_ack;
  assign ref_serve = ref_due && ready && !go;
  assign disp      = cand_v && ready && !go && !ref_due;

  assign pend_load = accept && (pend_v == disp);
  assign keep      = accept && (!pend_v || disp);

  assign sent_total = sent_acc + count_sent;
  assign new_len    = cur_len - len_t'(sent_total);

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      small_car      <= '0;
      big_car        <= '0;
      rd_q           <= 1'b0;
      fq_v           <= 1'b0;
      pend_v         <= 1'b0;
      inflight       <= '0;
      go             <= 1'b0;
      sched_wr       <= 1'b0;
      irq            <= 1'b0;
      ref_req        <= '0;
      ref_ack        <= '0;
      refresh_strobe <= 1'b0;
    end
    else
    begin
      if (small_car == SMALL_W'(SLOT_PERIOD - 1))
      begin
        small_car <= '0;
        big_car   <= big_car + 4'd1;
      end
      else
        small_car <= small_car + 1'b1;

      rd_q   <= sched_rd;
      fq_v   <= rd_q;
      pend_v <= pend_load || (pend_v && !disp);

      if (sched_wr)
        inflight[sched_wr_idx] <= 1'b0;
      if (keep)
        inflight[fq_idx] <= 1'b1;

      go       <= (done_pulse && restart) || disp;  // restart goes first
      sched_wr <= done_pulse && !restart;
      irq      <= done_pulse && !restart && (new_len == '0);

      if (slot_fast0 && big_car[0])
        ref_req <= ref_req + 2'd1;  // one per odd round
      if (ref_serve)
      begin
        ref_ack        <= ref_ack + 2'd1;
        refresh_strobe <= !refresh_strobe;
      end
    end
  end

  always_ff @(posedge CLK)
  begin
    rd_idx_q <= sched_rd_idx;
    fq_idx   <= rd_idx_q;
    fq_data  <= sched_rd_data;
    if (pend_load)
    begin
      pend_idx  <= fq_idx;
      pend_data <= fq_data;
    end

    if (done_pulse)
    begin
      if (restart)
      begin
        new_addr  <= old_addr;  // first word of the next page
        block_len <= block_len - count_sent;
        sent_acc  <= sent_total;
      end
      else
      begin
        sched_wr_idx  <= xfer_idx;
        sched_wr_data <= {cur_hi[7:5], new_len != '0, cur_hi[3:0], new_len, old_addr};
        irq_idx       <= xfer_idx;
      end
    end
    else if (disp)
    begin
      new_addr      <= cand_data[31:0];
      block_len     <= (cand_len > len_t'(BLK_MAX)) ? blk_len_t'(BLK_MAX) : cand_len[5:0];
      new_section   <= cand_data[SECT_LSB +: 2];
      new_dir       <= cand_data[DIR_BIT];
      select_mvblck <= {cand_data[DMEM_BIT], !cand_data[DMEM_BIT]};
      xfer_idx      <= cand_idx;
      cur_hi        <= cand_data[63:56];  // token travels to the write-back
      cur_len       <= cand_len;
      sent_acc      <= '0;
    end
  end

  a_go_needs_ready : assert property (@(posedge CLK) disable iff (!RST) go |-> ready);

endmodule

//--- tb/hyper_tb.sv
`timescale 1ns/1ps

module hyper_tb;
  import hyper_pkg::*;

  localparam int          SLOT_PERIOD    = 48;
  localparam logic [31:0] SEED           = 32'h3549_4d60;
  localparam int          REFRESH_WINDOW = 32 * SLOT_PERIOD;

  logic        CLK = 1'b0;
  logic        RST;
  logic        psel, penable, pwrite, pready;
  logic [4:0]  paddr;
  logic [31:0] pwdata, prdata;
  logic [7:0]  periph_busy;
  logic [1:0]  mcu_grant, mcu_req;
  page_t       page_addr;
  logic        xfer_valid, xfer_dir, irq, refresh_strobe;
  addr_t       xfer_addr;
  desc_idx_t   xfer_idx, irq_idx;
  section_t    xfer_section;

  // reference model
  desc_t      desc_word [8];
  addr_t      exp_addr [8];
  int         exp_len [8];
  int         start_len [8];
  int         beats [8];
  int         irq_count [8];
  logic [2:0] pid [8];        // {dir, section} of each entry
  int         total_len, irq_total, toggles, errors;
  int         tok_entry, hold_entry;
  logic [7:0] hold_mask;
  logic       tok_seen, window_on, run_open, last_strobe;
  page_t      run_page;

  hyper_top #(.SLOT_PERIOD(SLOT_PERIOD)) dut_i (
    .CLK(CLK), .RST(RST),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
    .pwdata(pwdata), .prdata(prdata), .pready(pready),
    .periph_busy(periph_busy), .mcu_grant(mcu_grant), .mcu_req(mcu_req),
    .page_addr(page_addr), .xfer_valid(xfer_valid), .xfer_addr(xfer_addr),
    .xfer_idx(xfer_idx), .xfer_dir(xfer_dir), .xfer_section(xfer_section),
    .irq(irq), .irq_idx(irq_idx), .refresh_strobe(refresh_strobe)
  );

  always #20 CLK = !CLK;

  // ----------------------------------------
  // helpers
  task automatic stop_on_error(input string what);
    errors++;
    $display("%s", what);
    $display("Checks failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp)
      stop_on_error($sformatf("FAIL %s: got %h, expected %h", name, got, exp));
  endtask

  // entry bits sit at 4:3 and 0 with the half select at 2
  function automatic logic [4:0] apb_addr(input int idx, input logic hi);
    return {idx[2:1], hi, 1'b0, idx[0]};
  endfunction

  // request line raised by the data-memory select of a descriptor
  function automatic logic [1:0] req_for(input desc_t d);
    return d[DMEM_BIT] ? 2'b10 : 2'b01;
  endfunction

  task automatic apb_access(input logic wr, input logic [4:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int waited;
    waited = 0;
    @(posedge CLK);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge CLK);
    penable <= 1'b1;
    @(negedge CLK);
    while (!pready)
    begin
      waited = waited + 1;
      if (waited > 20)
        stop_on_error("APB access saw no pready");
      @(negedge CLK);
    end
    rdata = prdata;
    @(posedge CLK);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic write_desc(input int idx, input desc_t value);
    logic [31:0] unused;
    apb_access(1'b1, apb_addr(idx, 1'b0), value[31:0], unused);  // staged
    apb_access(1'b1, apb_addr(idx, 1'b1), value[63:32], unused);
  endtask

  task automatic read_desc(input int idx, output desc_t value);
    logic [31:0] lo, hi;
    apb_access(1'b0, apb_addr(idx, 1'b0), 32'h0, lo);
    apb_access(1'b0, apb_addr(idx, 1'b1), 32'h0, hi);
    value = {hi, lo};
  endtask

  task automatic drive_random_inputs();
    forever
    begin
      @(posedge CLK);
      periph_busy <= 8'($urandom & $urandom) | hold_mask;  // about one in four busy
      mcu_grant   <= 2'($urandom);
    end
  endtask

  // ----------------------------------------
  // monitor sampled mid-cycle
  always @(negedge CLK)
  begin
    if (RST === 1'b1)
    begin
      if (mcu_req == 2'b00)
        run_open = 1'b0;
      if (xfer_valid)
      begin
        check_value("xfer_addr", xfer_addr, exp_addr[xfer_idx]);
        check_value("xfer_dir", xfer_dir, pid[xfer_idx][2]);
        check_value("xfer_section", xfer_section, pid[xfer_idx][1:0]);
        check_value("page_addr", page_addr, exp_addr[xfer_idx][31:PAGE_BITS]);
        check_value("mcu_req", mcu_req, req_for(desc_word[xfer_idx]));
        check_value("mcu_grant on beat", |(req_for(desc_word[xfer_idx]) & mcu_grant), 1'b1);
        if (exp_len[xfer_idx] == 0)
          stop_on_error($sformatf("beat for entry %0d after its length ran out", xfer_idx));
        if (xfer_idx == hold_entry && hold_mask != '0)
          stop_on_error("beat for an entry whose peripheral is held busy");
        if (!run_open)
        begin
          run_open = 1'b1;
          run_page = exp_addr[xfer_idx][31:PAGE_BITS];
        end
        else if (exp_addr[xfer_idx][31:PAGE_BITS] != run_page)
          stop_on_error("one engine block crossed a page edge");
        if (xfer_idx == tok_entry)
          tok_seen = 1'b1;
        exp_addr[xfer_idx] = exp_addr[xfer_idx] + 1;
        exp_len[xfer_idx]  = exp_len[xfer_idx] - 1;
        beats[xfer_idx]    = beats[xfer_idx] + 1;
      end
      if (irq)
      begin
        check_value($sformatf("words left at irq_idx %0d", irq_idx), exp_len[irq_idx], 0);
        check_value($sformatf("earlier irqs for irq_idx %0d", irq_idx), irq_count[irq_idx], 0);
        irq_count[irq_idx] = irq_count[irq_idx] + 1;
        irq_total = irq_total + 1;
      end
      if (window_on && refresh_strobe != last_strobe)
        toggles = toggles + 1;
      last_strobe = refresh_strobe;
    end
  end

  // watchdog
  initial
  begin
    int limit;
    wait (RST === 1'b1);
    limit = total_len * SLOT_PERIOD * 16 + REFRESH_WINDOW + 40 * SLOT_PERIOD;
    repeat (limit) @(posedge CLK);
    stop_on_error("watchdog expired before the DMA run finished");
  end

  // ----------------------------------------
  // main sequence
  initial
  begin
    desc_t      bulk [8];
    desc_t      rd_val, exp_val, cpu_val;
    addr_t      start;
    logic [2:0] tmp;
    int         j, exp_toggles;

    void'($urandom(SEED));
    RST         <= 1'b0;
    psel        <= 1'b0;
    penable     <= 1'b0;
    pwrite      <= 1'b0;
    paddr       <= '0;
    pwdata      <= '0;
    periph_busy <= '0;
    mcu_grant   <= '0;
    tok_seen    = 1'b0;
    window_on   = 1'b0;
    run_open    = 1'b0;
    last_strobe = 1'b0;
    irq_total   = 0;
    toggles     = 0;
    errors      = 0;
    total_len   = 0;

    for (int i = 0; i < 8; i++)
      pid[i] = 3'(i);
    for (int i = 7; i > 0; i--)
    begin
      j      = $urandom % (i + 1);  // shuffle so every entry owns one peripheral
      tmp    = pid[i];
      pid[i] = pid[j];
      pid[j] = tmp;
    end
    tok_entry  = $urandom % 2;
    hold_entry = 2 + $urandom % 6;
    hold_mask  = 8'(1) << pid[hold_entry];

    for (int i = 0; i < 8; i++)
    begin
      bulk[i] = {$urandom, $urandom};
      bulk[i][ACTIVE_BIT] = 1'b0;
      if (i == tok_entry)
      begin
        start_len[i] = 200 + $urandom % 100;
        start = (addr_t'($urandom % 32'hF_FFF0) << PAGE_BITS) | addr_t'($urandom % 2048);
      end
      else
      begin
        start_len[i] = (i < 2) ? 60 + $urandom % 200 : 20 + $urandom % 160;
        // close below a page edge
        start = (addr_t'($urandom % 32'hF_FFF0) << PAGE_BITS) | addr_t'(4095 - $urandom % 50);
      end
      exp_addr[i]  = start;
      exp_len[i]   = start_len[i];
      beats[i]     = 0;
      irq_count[i] = 0;
      total_len    = total_len + start_len[i];
      desc_word[i] = {2'($urandom), 1'($urandom), 1'b1, 1'($urandom), pid[i],
                      24'(start_len[i]), start};
    end
    cpu_val = {$urandom, $urandom};
    cpu_val[ACTIVE_BIT] = 1'b0;
    cpu_val[TOKEN_BIT]  = !desc_word[tok_entry][TOKEN_BIT];

    fork
      drive_random_inputs();
    join_none

    repeat (3) @(posedge CLK);
    RST <= 1'b1;

    // apb round trip with every entry idle
    for (int i = 0; i < 8; i++)
      write_desc(i, bulk[i]);
    for (int i = 0; i < 8; i++)
    begin
      read_desc(i, rd_val);
      check_value($sformatf("prdata entry %0d", i), rd_val, bulk[i]);
    end

    // token entry goes last so its first block is caught in flight
    for (int i = 0; i < 8; i++)
      if (i != tok_entry)
        write_desc(i, desc_word[i]);
    write_desc(tok_entry, desc_word[tok_entry]);
    wait (tok_seen);
    write_desc(tok_entry, cpu_val);

    while (irq_total < 6)
      @(posedge CLK);
    hold_mask <= '0;
    while (irq_total < 7)
      @(posedge CLK);
    repeat (4 * SLOT_PERIOD) @(posedge CLK);

    for (int i = 0; i < 8; i++)
    begin
      read_desc(i, rd_val);
      if (i == tok_entry)
        check_value("prdata after cpu rewrite", rd_val, cpu_val);
      else
      begin
        check_value($sformatf("beats for entry %0d", i), beats[i], start_len[i]);
        exp_val = desc_word[i];
        exp_val[ACTIVE_BIT] = 1'b0;
        exp_val[55:32] = '0;
        exp_val[31:0]  = desc_word[i][31:0] + addr_t'(start_len[i]);
        check_value($sformatf("prdata entry %0d after drain", i), rd_val, exp_val);
      end
    end

    // refresh rate with the engine idle
    repeat (2 * SLOT_PERIOD) @(posedge CLK);
    window_on <= 1'b1;
    repeat (REFRESH_WINDOW) @(posedge CLK);
    window_on <= 1'b0;
    @(posedge CLK);
    exp_toggles = REFRESH_WINDOW / (2 * SLOT_PERIOD);
    if (toggles < exp_toggles - 1 || toggles > exp_toggles + 1)
      stop_on_error($sformatf("FAIL refresh_strobe toggles: got %h, expected %h +/- 1",
                              toggles, exp_toggles));

    if (errors == 0)
    begin
      $display("All checks passed");
      $finish;
    end
    else
    begin
      $display("Checks failed");
      $fatal(1, "errors were found");
    end
  end

endmodule
